// ==== hw/rx_defines.svh ====
// needs RX_CHANS of 2 or more, 24-bit samples and a power-of-two buffer depth; nsamps of 0 is not valid
`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

////////////////////////////////////////////////////////////
// channel and sample geometry
////////////////////////////////////////////////////////////

`define RX_CHANS       4     // audio channels interleaved per sample
`define RX_SAMP_W      24    // I and Q width from each down-converter
`define RX_WORD_W      16    // buffer word
`define RX_TICKS_W     48    // free-running tick count
`define RX_NSAMPS_W    8     // sample count register

// buffer depth in words, pointers wrap at this size
`define RXBUF_DEPTH    2048

////////////////////////////////////////////////////////////
// one-hot op bits, qualified by the register or event strobes
////////////////////////////////////////////////////////////

`define OP_SET_RX_NSAMPS  0  // wr_reg: load sample count from tos
`define OP_GET_RX_SAMP    1  // wr_evt: read next buffer word
`define OP_GET_BUF_CTR    2  // wr_evt: read frame counter
`define OP_GET_RX_SRQ     3  // rd_reg: poll service request

`define RX_OP_W        16    // op word width
`define RX_TOS_W       16    // top-of-stack data width

`endif

// ==== hw/rx_pkg.sv ====
// relies on rx_defines.svh on the include path; the channel index is sized for RX_CHANS of 2 or more
`include "rx_defines.svh"

package rx_pkg;

	////////////////////////////////////////////////////////////
	// buffer word and tick views
	////////////////////////////////////////////////////////////

	typedef logic [`RX_WORD_W-1:0] rx_word_t;	// one buffer word

	// the latched tick count, stored whole but written out word by word
	typedef union packed
	{
		logic [`RX_TICKS_W-1:0] count;		// as counted
		rx_word_t [2:0] w;			// w[0] is the low word, written first
	} rx_ticks_u;

	// channel index into the interleaved groups
	typedef logic [$clog2(`RX_CHANS)-1:0] rx_chan_t;

	// word within a group of three
	typedef enum logic [1:0]
	{
		TSEL_I  = 2'd0,	// I high bits
		TSEL_Q  = 2'd1,	// Q high bits
		TSEL_LB = 2'd2	// low bytes of I and Q
	} rx_tsel_t;

endpackage

// ==== hw/rx_wr_if.sv ====
// all fields are registered by the sequencer and line up with the cycle in which the word is written
`include "rx_defines.svh"

interface rx_wr_if
	import rx_pkg::*;
();

	logic wr;		// write strobe, one word per cycle
	rx_tsel_t tsel;		// I, Q or low-bytes word (also tick word 0..2)
	rx_chan_t chan;		// channel of the group being written
	logic use_ts;		// trailer: tick words
	logic use_ctr;		// trailer: frame counter word

	// transfer sequencer drives everything
	modport seq (output wr, output tsel, output chan, output use_ts, output use_ctr);

	// word source picks the data from the selectors
	modport src (input tsel, input chan, input use_ts, input use_ctr);

	// sample buffer only needs the strobe
	modport sbuf (input wr);

endinterface

// ==== hw/rx_ctrl_regs.sv ====
// op bits are one-hot and only act with their strobe; nsamps has no reset and must be written before use
`include "rx_defines.svh"

module rx_ctrl_regs
(
	input  logic adc_clk,
	input  logic reset_bufs_A,
	input  logic [`RX_OP_W-1:0] op_i,
	input  logic wr_reg_i,
	input  logic wr_evt_i,
	input  logic rd_reg_i,
	input  logic [`RX_TOS_W-1:0] tos_i,
	input  logic frame_done_i,
	output logic [`RX_NSAMPS_W-1:0] nsamps_o,
	output logic rd_samp_o,
	output logic rd_ctr_o,
	output logic ser_o
);

	logic set_nsamps;
	logic get_srq;
	logic srq_noted;	// frame completed since last poll

	////////////////////////////////////////////////////////////
	// command decode
	////////////////////////////////////////////////////////////

	assign set_nsamps = wr_reg_i & op_i[`OP_SET_RX_NSAMPS];
	assign rd_samp_o  = wr_evt_i & op_i[`OP_GET_RX_SAMP];	// next buffer word
	assign rd_ctr_o   = wr_evt_i & op_i[`OP_GET_BUF_CTR];	// frame counter
	assign get_srq    = rd_reg_i & op_i[`OP_GET_RX_SRQ];

	// samples per frame, survives a buffer reset
	always_ff @(posedge adc_clk)
	begin
		if (set_nsamps)
			nsamps_o <= tos_i[`RX_NSAMPS_W-1:0];
	end

	////////////////////////////////////////////////////////////
	// service request
	////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			srq_noted <= 1'b0;
			ser_o <= 1'b0;
		end
		else if (get_srq)
		begin
			ser_o <= srq_noted;		// report and start over
			srq_noted <= frame_done_i;	// a pulse in the poll cycle is kept
		end
		else
			srq_noted <= srq_noted | frame_done_i;
	end

endmodule

// ==== hw/rx_xfer_seq.sv ====
// rx_avail_i must be spaced at least 3*RX_CHANS+8 cycles apart; a pulse during a transfer is dropped
`include "rx_defines.svh"

module rx_xfer_seq
	import rx_pkg::*;
(
	input  logic adc_clk,
	input  logic reset_bufs_A,
	input  logic rx_avail_i,
	input  logic [`RX_NSAMPS_W-1:0] nsamps_i,
	rx_wr_if.seq wr_bus,
	output logic frame_done_o
);

	// count runs 0..nsamps-1 over the sample bursts,
	// nsamps while the tick words go out, nsamps+1 for the counter word
	logic transfer;			// a burst or the trailer is moving
	logic [`RX_NSAMPS_W:0] count;
	rx_chan_t chan_n;		// channel of the next group
	rx_tsel_t move;			// next word within the group
	logic [`RX_NSAMPS_W:0] n_full;
	logic last_chan;

	assign n_full = {1'b0, nsamps_i};
	assign last_chan = (chan_n == rx_chan_t'(`RX_CHANS - 1));

	////////////////////////////////////////////////////////////
	// transfer state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			transfer <= 1'b0;
			count <= '0;
			chan_n <= '0;
			move <= TSEL_I;
			wr_bus.wr <= 1'b0;
			wr_bus.tsel <= TSEL_I;
			wr_bus.chan <= '0;
			wr_bus.use_ts <= 1'b0;
			wr_bus.use_ctr <= 1'b0;
			frame_done_o <= 1'b0;
		end
		else
		begin
			// one cycle after the counter word went out
			frame_done_o <= wr_bus.wr & wr_bus.use_ctr;

			if (!transfer)
			begin
				// idle, wait for the down-converters
				wr_bus.wr <= 1'b0;
				wr_bus.use_ts <= 1'b0;
				wr_bus.use_ctr <= 1'b0;
				transfer <= rx_avail_i;
			end
			else if (count < n_full)
			begin
				// channel groups: I, Q, low bytes for each channel in turn
				wr_bus.wr <= 1'b1;
				wr_bus.use_ts <= 1'b0;
				wr_bus.use_ctr <= 1'b0;
				wr_bus.chan <= chan_n;
				wr_bus.tsel <= move;
				if (move == TSEL_LB)
				begin
					move <= TSEL_I;
					chan_n <= last_chan ? '0 : chan_n + 1'b1;
					if (last_chan)
					begin
						count <= count + 1'b1;
						// last burst runs straight on into the trailer
						transfer <= (count == n_full - 1'b1);
					end
				end
				else
					move <= (move == TSEL_I) ? TSEL_Q : TSEL_LB;
			end
			else if (count == n_full)
			begin
				// three tick words, low first, tsel reused as word index
				wr_bus.wr <= 1'b1;
				wr_bus.use_ts <= 1'b1;
				wr_bus.use_ctr <= 1'b0;
				wr_bus.tsel <= move;
				if (move == TSEL_LB)
				begin
					move <= TSEL_I;
					count <= count + 1'b1;
				end
				else
					move <= (move == TSEL_I) ? TSEL_Q : TSEL_LB;
			end
			else
			begin
				// frame counter word closes the frame
				wr_bus.wr <= 1'b1;
				wr_bus.use_ts <= 1'b0;
				wr_bus.use_ctr <= 1'b1;
				count <= '0;
				transfer <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/rx_word_src.sv ====
// samples and ticks are caught on every rx_avail_i, so they must hold until the burst has been written
`include "rx_defines.svh"

module rx_word_src
	import rx_pkg::*;
(
	input  logic adc_clk,
	input  logic reset_bufs_A,
	input  logic rx_avail_i,
	input  logic [`RX_CHANS*`RX_SAMP_W-1:0] rx_i_i,
	input  logic [`RX_CHANS*`RX_SAMP_W-1:0] rx_q_i,
	input  logic [`RX_TICKS_W-1:0] ticks_i,
	input  logic frame_done_i,
	rx_wr_if.src wr_bus,
	output rx_word_t din_o,
	output rx_word_t buf_ctr_o
);

	logic [`RX_CHANS*`RX_SAMP_W-1:0] i_lat, q_lat;	// all channels, packed
	rx_ticks_u ticks_lat;
	rx_word_t frame_ctr;		// frames completed
	logic [`RX_SAMP_W-1:0] i_sel, q_sel;
	rx_word_t samp_word, tick_word;

	////////////////////////////////////////////////////////////
	// sample and tick latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (rx_avail_i)
		begin
			i_lat <= rx_i_i;
			q_lat <= rx_q_i;
			ticks_lat.count <= ticks_i;	// last pulse of a frame wins
		end
	end

	// counts frames, cleared only with the buffers
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			frame_ctr <= '0;
		else if (frame_done_i)
			frame_ctr <= frame_ctr + 1'b1;
	end

	assign buf_ctr_o = frame_ctr;

	////////////////////////////////////////////////////////////
	// write word select
	////////////////////////////////////////////////////////////

	always_comb
	begin
		i_sel = i_lat[wr_bus.chan*`RX_SAMP_W +: `RX_SAMP_W];
		q_sel = q_lat[wr_bus.chan*`RX_SAMP_W +: `RX_SAMP_W];
		case (wr_bus.tsel)
			TSEL_I:  samp_word = i_sel[`RX_SAMP_W-1 -: 16];
			TSEL_Q:  samp_word = q_sel[`RX_SAMP_W-1 -: 16];
			default: samp_word = {i_sel[7:0], q_sel[7:0]};	// I low byte on top
		endcase
		case (wr_bus.tsel)
			TSEL_I:  tick_word = ticks_lat.w[0];	// low
			TSEL_Q:  tick_word = ticks_lat.w[1];
			default: tick_word = ticks_lat.w[2];	// high
		endcase
	end

	assign din_o = wr_bus.use_ctr ? frame_ctr :
		(wr_bus.use_ts ? tick_word : samp_word);

endmodule

// ==== hw/rx_sample_buf.sv ====
// no overflow or underflow detection; the host must not read words that have not been written yet
`include "rx_defines.svh"

module rx_sample_buf
	import rx_pkg::*;
(
	input  logic adc_clk,
	input  logic reset_bufs_A,
	rx_wr_if.sbuf wr_bus,
	input  rx_word_t din_i,
	input  logic rd_samp_i,
	input  logic rd_ctr_i,
	input  rx_word_t buf_ctr_i,
	output rx_word_t rx_dout_o,
	output logic rx_rd_o
);

	localparam int ADDR_W = $clog2(`RXBUF_DEPTH);

	rx_word_t mem [`RXBUF_DEPTH];
	logic [ADDR_W-1:0] waddr;	// next word to write
	logic [ADDR_W-1:0] raddr;	// next word to read

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	always_ff @(posedge adc_clk)
	begin
		if (wr_bus.wr)
			mem[waddr] <= din_i;
	end

	// both pointers just wrap
	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
		begin
			waddr <= '0;
			raddr <= '0;
		end
		else
		begin
			if (wr_bus.wr)
				waddr <= waddr + 1'b1;
			if (rd_samp_i)
				raddr <= raddr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// read port
	////////////////////////////////////////////////////////////

	// data one cycle after the event
	always_ff @(posedge adc_clk)
	begin
		if (rd_ctr_i)
			rx_dout_o <= buf_ctr_i;		// counter read wins
		else if (rd_samp_i)
			rx_dout_o <= mem[raddr];
	end

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			rx_rd_o <= 1'b0;
		else
			rx_rd_o <= rd_samp_i | rd_ctr_i;	// one-cycle strobe per event
	end

endmodule

// ==== hw/rx_audio_buffer.sv ====
// single clock domain; rx_i_i and rx_q_i are only sampled in the rx_avail_i cycle, channel 0 in the low bits
`include "rx_defines.svh"

module rx_audio_buffer
	import rx_pkg::*;
(
	input  logic adc_clk,
	input  logic reset_bufs_A,
	input  logic rx_avail_i,
	input  logic [`RX_CHANS*`RX_SAMP_W-1:0] rx_i_i,
	input  logic [`RX_CHANS*`RX_SAMP_W-1:0] rx_q_i,
	input  logic [`RX_TICKS_W-1:0] ticks_i,
	input  logic [`RX_OP_W-1:0] op_i,
	input  logic wr_reg_i,
	input  logic wr_evt_i,
	input  logic rd_reg_i,
	input  logic [`RX_TOS_W-1:0] tos_i,
	output logic [`RX_WORD_W-1:0] rx_dout_o,
	output logic rx_rd_o,
	output logic ser_o
);

	logic [`RX_NSAMPS_W-1:0] nsamps;
	logic rd_samp, rd_ctr;		// decoded read events
	logic frame_done;
	rx_word_t din;			// word being written
	rx_word_t buf_ctr;		// frames completed

	rx_wr_if wr_bus ();		// sequencer to word source and buffer

	////////////////////////////////////////////////////////////
	// command side
	////////////////////////////////////////////////////////////

	rx_ctrl_regs ctrl_regs (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.op_i         (op_i),
		.wr_reg_i     (wr_reg_i),
		.wr_evt_i     (wr_evt_i),
		.rd_reg_i     (rd_reg_i),
		.tos_i        (tos_i),
		.frame_done_i (frame_done),
		.nsamps_o     (nsamps),
		.rd_samp_o    (rd_samp),
		.rd_ctr_o     (rd_ctr),
		.ser_o        (ser_o)
	);

	////////////////////////////////////////////////////////////
	// write path
	////////////////////////////////////////////////////////////

	rx_xfer_seq xfer_seq (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.rx_avail_i   (rx_avail_i),
		.nsamps_i     (nsamps),
		.wr_bus       (wr_bus.seq),
		.frame_done_o (frame_done)
	);

	rx_word_src word_src (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.rx_avail_i   (rx_avail_i),
		.rx_i_i       (rx_i_i),
		.rx_q_i       (rx_q_i),
		.ticks_i      (ticks_i),
		.frame_done_i (frame_done),
		.wr_bus       (wr_bus.src),
		.din_o        (din),
		.buf_ctr_o    (buf_ctr)
	);

	// memory and host read port
	rx_sample_buf sample_buf (
		.adc_clk      (adc_clk),
		.reset_bufs_A (reset_bufs_A),
		.wr_bus       (wr_bus.sbuf),
		.din_i        (din),
		.rd_samp_i    (rd_samp),
		.rd_ctr_i     (rd_ctr),
		.buf_ctr_i    (buf_ctr),
		.rx_dout_o    (rx_dout_o),
		.rx_rd_o      (rx_rd_o)
	);

endmodule

// ==== bench/rx_buf_checker.sv ====
// bound into every rx_audio_buffer; rules are sampled on adc_clk and held off while reset_bufs_A is high
`include "rx_defines.svh"

module rx_buf_checker
(
	input logic adc_clk,
	input logic reset_bufs_A,
	input logic rx_avail_i,
	input logic [`RX_OP_W-1:0] op_i,
	input logic wr_evt_i,
	input logic rd_reg_i,
	input logic rx_rd_o,
	input logic ser_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MIN_GAP = 3 * `RX_CHANS + 8;

	logic read_evt, poll;
	logic [7:0] gap_cnt;	// cycles since last rx_avail_i, saturates

	assign read_evt = wr_evt_i & (op_i[`OP_GET_RX_SAMP] | op_i[`OP_GET_BUF_CTR]);
	assign poll = rd_reg_i & op_i[`OP_GET_RX_SRQ];

	always_ff @(posedge adc_clk)
	begin
		if (reset_bufs_A)
			gap_cnt <= 8'(MIN_GAP);		// first pulse is always fine
		else if (rx_avail_i)
			gap_cnt <= 8'd1;
		else if (gap_cnt < 8'(MIN_GAP))
			gap_cnt <= gap_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// handshake and timing rules
	////////////////////////////////////////////////////////////

	rd_strobe_follows_event: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		rx_rd_o |-> $past(read_evt))
		else $error("rx_rd_o without a read event one cycle before");

	event_gives_strobe: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		read_evt |=> rx_rd_o)
		else $error("read event not answered by rx_rd_o");

	avail_spacing: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		rx_avail_i |-> gap_cnt >= 8'(MIN_GAP))
		else $error("rx_avail_i pulses closer than the minimum spacing");

	// ser_o only moves on the edge that takes a poll
	ser_only_on_poll: assert property (@(posedge adc_clk) disable iff (reset_bufs_A)
		!$stable(ser_o) |-> ($past(poll) || $past(reset_bufs_A)))
		else $error("ser_o changed without a poll");

endmodule

bind rx_audio_buffer rx_buf_checker buf_chk (
	.adc_clk      (adc_clk),
	.reset_bufs_A (reset_bufs_A),
	.rx_avail_i   (rx_avail_i),
	.op_i         (op_i),
	.wr_evt_i     (wr_evt_i),
	.rd_reg_i     (rd_reg_i),
	.rx_rd_o      (rx_rd_o),
	.ser_o        (ser_o)
);

// ==== bench/tb_rx_audio_buffer.sv ====
// directed tests for rx_audio_buffer; expects RX_CHANS of 2 or more and nsamps of 1 or 3 only, frames must fit the buffer
`include "rx_defines.svh"

module tb_rx_audio_buffer
	import rx_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYC = 10;
	localparam int GROUP_WORDS = 3 * `RX_CHANS;	// words per sample burst
	localparam int AVAIL_GAP = GROUP_WORDS + 10;	// above the 3*chans+8 minimum
	localparam int POLL_LIMIT = GROUP_WORDS + 16;

	logic adc_clk, reset_bufs_A, rx_avail_i;
	logic [`RX_CHANS*`RX_SAMP_W-1:0] rx_i_i, rx_q_i;
	logic [`RX_TICKS_W-1:0] ticks_i;
	logic [`RX_OP_W-1:0] op_i;
	logic wr_reg_i, wr_evt_i, rd_reg_i;
	logic [`RX_TOS_W-1:0] tos_i;
	logic [`RX_WORD_W-1:0] rx_dout_o;
	logic rx_rd_o, ser_o;

	rx_word_t exp_q[$];		// expected buffer words, oldest first
	int frames_done;		// model of the frame counter

	rx_audio_buffer uut (.*);

	initial
	begin
		adc_clk = 1'b0;
		forever #2 adc_clk = ~adc_clk;	// 4 ns period
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic step();
		@(posedge adc_clk);
		#1;	// drive just after the edge
	endtask

	task automatic report_stop(input string why);
		$display("Error: %s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_val(input string name, input logic [47:0] got, input logic [47:0] exp);
		if (got !== exp)
		begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
			report_stop("value mismatch");
		end
	endtask

	task automatic apply_reset();
		reset_bufs_A = 1'b1;
		repeat (RESET_CYC) step();
		reset_bufs_A = 1'b0;
		exp_q.delete();
		frames_done = 0;	// counter clears with the buffers
	endtask

	task automatic set_nsamps(input int n);
		op_i = '0;
		op_i[`OP_SET_RX_NSAMPS] = 1'b1;
		tos_i = 16'(n);
		wr_reg_i = 1'b1;
		step();
		wr_reg_i = 1'b0;
		op_i = '0;
	endtask

	// one pulse with fresh random samples, group words go into the model
	task automatic send_sample();
		logic [`RX_SAMP_W-1:0] i_s, q_s;
		for (int c = 0; c < `RX_CHANS; c++)
		begin
			i_s = 24'($urandom);
			q_s = 24'($urandom);
			rx_i_i[c*`RX_SAMP_W +: `RX_SAMP_W] = i_s;	// channel 0 in the low bits
			rx_q_i[c*`RX_SAMP_W +: `RX_SAMP_W] = q_s;
			exp_q.push_back(i_s[23:8]);
			exp_q.push_back(q_s[23:8]);
			exp_q.push_back({i_s[7:0], q_s[7:0]});	// I low byte on top
		end
		ticks_i = {16'($urandom), $urandom};
		rx_avail_i = 1'b1;
		step();
		rx_avail_i = 1'b0;
	endtask

	// poll the request, ser_o is valid right after the edge
	task automatic poll_srq();
		op_i = '0;
		op_i[`OP_GET_RX_SRQ] = 1'b1;
		rd_reg_i = 1'b1;
		step();
		rd_reg_i = 1'b0;
		op_i = '0;
	endtask

	task automatic wait_frame();
		int polls;
		polls = 0;
		poll_srq();
		while (!ser_o && polls < POLL_LIMIT)
		begin
			poll_srq();
			polls++;
		end
		if (!ser_o)
			report_stop("frame did not complete, ser_o stayed low");
	endtask

	// n spaced pulses, then ticks of the last pulse and the counter
	task automatic run_frame(input int n);
		for (int p = 0; p < n; p++)
		begin
			send_sample();
			if (p < n - 1)
				repeat (AVAIL_GAP - 1) step();
		end
		exp_q.push_back(ticks_i[15:0]);
		exp_q.push_back(ticks_i[31:16]);
		exp_q.push_back(ticks_i[47:32]);
		exp_q.push_back(16'(frames_done));
		wait_frame();
		frames_done++;
	endtask

	task automatic read_event(input int op_bit, output rx_word_t word);
		op_i = '0;
		op_i[op_bit] = 1'b1;
		wr_evt_i = 1'b1;
		step();
		wr_evt_i = 1'b0;
		op_i = '0;
		// strobe and data one cycle after the event
		if (!rx_rd_o)
			report_stop("read event got no rx_rd_o strobe one cycle later");
		else
		begin
			word = rx_dout_o;
			step();
			check_val("rx_rd_o", rx_rd_o, 0);	// strobe lasts one cycle
		end
	endtask

	task automatic read_frame(input int n);
		rx_word_t got;
		for (int k = 0; k < n; k++)
		begin
			read_event(`OP_GET_RX_SAMP, got);
			check_val("rx_dout_o", got, exp_q.pop_front());
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic after_reset_values();
		rx_word_t got;
		check_val("ser_o", ser_o, 0);
		check_val("rx_rd_o", rx_rd_o, 0);
		read_event(`OP_GET_BUF_CTR, got);
		check_val("buf_ctr", got, 0);
	endtask

	task automatic single_sample_frame();
		set_nsamps(1);
		run_frame(1);
		read_frame(GROUP_WORDS + 4);
	endtask

	task automatic three_sample_frame();
		set_nsamps(3);
		run_frame(3);	// ticks from the third pulse
		read_frame(3 * GROUP_WORDS + 4);
	endtask

	task automatic service_request_flag();
		set_nsamps(1);
		run_frame(1);	// returns once a poll saw ser_o high
		poll_srq();
		check_val("ser_o", ser_o, 0);	// no frame since then
		read_frame(exp_q.size());
	endtask

	task automatic frame_counter_count();
		rx_word_t got;
		set_nsamps(1);
		run_frame(1);
		read_frame(exp_q.size());
		read_event(`OP_GET_BUF_CTR, got);
		check_val("buf_ctr", got, frames_done);
		run_frame(1);	// counter word inside must equal k
		read_frame(exp_q.size());
	endtask

	task automatic reset_mid_readout();
		rx_word_t got;
		set_nsamps(1);
		run_frame(1);
		read_frame(5);
		apply_reset();
		read_event(`OP_GET_BUF_CTR, got);
		check_val("buf_ctr", got, 0);
		set_nsamps(1);
		run_frame(1);
		read_frame(GROUP_WORDS + 4);	// from the first word again
	endtask

	////////////////////////////////////////////////////////////
	// run and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		int budget;
		// one frame: pulses, polls, two cycles per read
		budget = 6 * (AVAIL_GAP + POLL_LIMIT + 2 * (GROUP_WORDS + 4) + 8);
		budget += 3 * AVAIL_GAP + POLL_LIMIT + 2 * (3 * GROUP_WORDS + 4) + 8;
		budget = 2 * (budget + 3 * RESET_CYC);
		repeat (budget) @(posedge adc_clk);
		report_stop("watchdog timeout, tests ran too long");
	end

	initial
	begin
		void'($urandom(32'hb336));
		frames_done = 0;
		reset_bufs_A = 1'b1;
		rx_avail_i = 1'b0;
		rx_i_i = '0;
		rx_q_i = '0;
		ticks_i = '0;
		op_i = '0;
		wr_reg_i = 1'b0;
		wr_evt_i = 1'b0;
		rd_reg_i = 1'b0;
		tos_i = '0;
		apply_reset();
		after_reset_values();
		single_sample_frame();
		three_sample_frame();
		service_request_flag();
		frame_counter_count();
		reset_mid_readout();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+hw
hw/rx_pkg.sv
hw/rx_wr_if.sv
hw/rx_ctrl_regs.sv
hw/rx_xfer_seq.sv
hw/rx_word_src.sv
hw/rx_sample_buf.sv
hw/rx_audio_buffer.sv
bench/rx_buf_checker.sv
bench/tb_rx_audio_buffer.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rx_audio_buffer \
	-Mdir obj_dir -o sim_rx_audio_buffer \
	-f list.f

# a failing run exits nonzero, the log decides the result
./obj_dir/sim_rx_audio_buffer > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log
then
	echo "run.sh: simulation passed"
	exit 0
fi

echo "run.sh: simulation failed"
exit 1
